// ==== hw/cpu88_pkg.sv ====
`default_nettype none

package cpu88_pkg;

    // ==================================================
    // Basic types
    // ==================================================

    typedef logic [15:0] word_t;
    typedef logic [19:0] addr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [11:0] flags_t;

    // Register 4 is the stack pointer
    localparam reg_idx_t SP_IDX = 3'd4;

    // Sequencer states
    typedef enum logic [2:0] {
        PREPARE,
        MAIN,
        IMMEDIATE,
        FETCHRM,
        PUSH
    } mode_e;

    // Same coding as the reg field of the ALU group
    typedef enum logic [2:0] {
        ADD        = 3'd0,
        OR         = 3'd1,
        ADC_UNUSED = 3'd2,
        SBB_UNUSED = 3'd3,
        AND        = 3'd4,
        SUB        = 3'd5,
        XOR        = 3'd6,
        CMP        = 3'd7
    } alu_op_e;

    // Base opcodes decoded by exact value
    typedef enum logic [7:0] {
        PUSHF     = 8'h9C,
        CMC       = 8'hF5,
        CLC       = 8'hF8,
        STC       = 8'hF9,
        JMP_SHORT = 8'hEB,
        HLT       = 8'hF4
    } opcode_e;

    // Carry flag operations
    typedef enum logic [1:0] {
        FLAG_NONE,
        FLAG_CLC,
        FLAG_STC,
        FLAG_CMC
    } flag_op_e;

    // Flag positions in the flags word
    localparam int CF_BIT = 0;
    localparam int ZF_BIT = 6;
    localparam int SF_BIT = 7;
    localparam int OF_BIT = 11;

    localparam word_t RESET_CS  = 16'hF000;
    localparam word_t STACK_SEG = 16'h0000;

endpackage

`default_nettype wire

// ==== hw/cpu88_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cpu88_ctrl_if;
    import cpu88_pkg::*;

    reg_idx_t rd_a;
    reg_idx_t rd_b;
    reg_idx_t wr_idx;
    logic     reg_we;
    logic     wb_sel;
    alu_op_e  alu_op;
    logic     alu_go;
    logic     alu_inc;
    logic [3:0] cond;
    flag_op_e flag_op;
    logic     ip_inc;
    logic     ip_dec;
    logic     ip_branch;
    logic     imm_load_lo;
    logic     imm_load_hi;
    logic     push_start;
    logic     push_hi;
    logic     push_src;

    // Returned by the data modules
    logic     branch_true;
    word_t    rdata_a;
    word_t    rdata_b;
    word_t    wr_data;
    word_t    sp;
    flags_t   flags;

    modport seq (
        output rd_a, rd_b, wr_idx, reg_we, wb_sel, alu_op, alu_go, alu_inc, cond,
        output flag_op, ip_inc, ip_dec, ip_branch, imm_load_lo, imm_load_hi,
        output push_start, push_hi, push_src,
        input  branch_true
    );

    modport regs (
        input  rd_a, rd_b, wr_idx, reg_we, wr_data, push_start,
        output rdata_a, rdata_b, sp
    );

    modport alu (
        input  rdata_a, rdata_b, wb_sel, alu_op, alu_go, alu_inc, cond, flag_op,
        output branch_true, flags
    );

    modport bus (
        input  ip_inc, ip_dec, ip_branch, imm_load_lo, imm_load_hi,
        input  push_start, push_hi, push_src
    );

endinterface

`default_nettype wire

// ==== hw/cpu88_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu88_sequencer #(
    parameter int STEP_WIDTH = 3
) (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  locked,
    input  logic [7:0]            bus,
    cpu88_ctrl_if.seq             ctrl,
    input  logic [STEP_WIDTH-1:0] step_count,
    input  logic                  step_last,
    output logic                  step_clear,
    output logic                  step_advance
);
    import cpu88_pkg::*;

    mode_e      mode;
    mode_e      mode_next;
    logic [7:0] opcode;
    reg_idx_t   rm_f;
    reg_idx_t   reg_f;
    reg_idx_t   dst_idx;
    reg_idx_t   src_idx;
    logic       first;

    // Direction bit picks which field is the destination
    assign dst_idx = opcode[1] ? reg_f : rm_f;
    assign src_idx = opcode[1] ? rm_f : reg_f;
    assign first   = (step_count == '0);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            mode   <= PREPARE;
            opcode <= '0;
        end else if (locked) begin
            mode <= mode_next;
            if (mode == PREPARE) begin
                opcode <= bus;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (locked && mode == FETCHRM) begin
            rm_f  <= bus[2:0];
            reg_f <= bus[5:3];
        end
    end

    // ==================================================
    // Control decode
    // ==================================================

    always_comb begin
        ctrl.rd_a        = dst_idx;
        ctrl.rd_b        = src_idx;
        ctrl.wr_idx      = dst_idx;
        ctrl.reg_we      = 1'b0;
        ctrl.wb_sel      = 1'b0;
        ctrl.alu_op      = alu_op_e'(opcode[5:3]);
        ctrl.alu_go      = 1'b0;
        ctrl.alu_inc     = 1'b0;
        ctrl.cond        = opcode[3:0];
        ctrl.flag_op     = FLAG_NONE;
        ctrl.ip_inc      = 1'b0;
        ctrl.ip_dec      = 1'b0;
        ctrl.ip_branch   = 1'b0;
        ctrl.imm_load_lo = 1'b0;
        ctrl.imm_load_hi = 1'b0;
        ctrl.push_start  = 1'b0;
        ctrl.push_hi     = 1'b0;
        ctrl.push_src    = (opcode == PUSHF);
        step_clear       = 1'b0;
        step_advance     = 1'b1;
        mode_next        = mode;

        case (mode)
            PREPARE: begin
                ctrl.ip_inc = 1'b1;
                step_clear  = 1'b1;
                mode_next   = MAIN;
            end

            MAIN: begin
                mode_next = PREPARE;
                casez (opcode)
                    // ALU r16, r16
                    8'b00???0?1: begin
                        if (opcode[5:4] != 2'b01 && first) begin
                            mode_next = FETCHRM;
                        end else if (opcode[5:4] != 2'b01) begin
                            ctrl.alu_go = 1'b1;
                            ctrl.reg_we = (alu_op_e'(opcode[5:3]) != CMP);
                        end
                    end
                    // INC / DEC r16
                    8'b0100????: begin
                        ctrl.rd_a    = opcode[2:0];
                        ctrl.wr_idx  = opcode[2:0];
                        ctrl.alu_op  = opcode[3] ? SUB : ADD;
                        ctrl.alu_inc = 1'b1;
                        if (first) begin
                            mode_next = MAIN;
                        end else begin
                            ctrl.alu_go = 1'b1;
                            ctrl.reg_we = 1'b1;
                        end
                    end
                    8'b01010???, PUSHF: begin
                        if (first) begin
                            step_clear = 1'b1;
                            mode_next  = PUSH;
                        end
                    end
                    // JO JNO JC JNC JZ JNZ JS JNS
                    8'b011100??, 8'b0111010?, 8'b0111100?: begin
                        ctrl.ip_inc    = 1'b1;
                        ctrl.ip_branch = ctrl.branch_true;
                    end
                    JMP_SHORT: begin
                        ctrl.ip_inc    = 1'b1;
                        ctrl.ip_branch = 1'b1;
                    end
                    // MOV r16, imm16
                    8'b10111???: begin
                        ctrl.wr_idx = opcode[2:0];
                        ctrl.wb_sel = 1'b1;
                        if (first) begin
                            step_clear = 1'b1;
                            mode_next  = IMMEDIATE;
                        end else begin
                            ctrl.reg_we = 1'b1;
                        end
                    end
                    CLC: ctrl.flag_op = FLAG_CLC;
                    STC: ctrl.flag_op = FLAG_STC;
                    CMC: ctrl.flag_op = FLAG_CMC;
                    // Step back once, then sit on the HLT byte
                    HLT: begin
                        mode_next    = MAIN;
                        ctrl.ip_dec  = first;
                        step_advance = first;
                    end
                    default: mode_next = PREPARE;
                endcase
            end

            FETCHRM: begin
                ctrl.ip_inc = 1'b1;
                mode_next   = MAIN;
            end

            IMMEDIATE: begin
                ctrl.ip_inc      = 1'b1;
                ctrl.imm_load_lo = !step_last;
                ctrl.imm_load_hi = step_last;
                if (step_last) begin
                    mode_next = MAIN;
                end
            end

            PUSH: begin
                ctrl.rd_a       = opcode[2:0];
                ctrl.push_start = !step_last;
                ctrl.push_hi    = step_last;
                if (step_last) begin
                    mode_next = MAIN;
                end
            end

            default: mode_next = PREPARE;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/cpu88_step_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu88_step_counter #(
    parameter int STEP_WIDTH = 3
) (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  locked,
    input  logic                  clear,
    input  logic                  advance,
    output logic [STEP_WIDTH-1:0] count,
    output logic                  last
);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            count <= '0;
        end else if (locked) begin
            if (clear) begin
                count <= '0;
            end else if (advance) begin
                count <= count + 1'b1;
            end
        end
    end

    // Second byte of a two-byte transfer
    assign last = (count == STEP_WIDTH'(1));

endmodule

`default_nettype wire

// ==== hw/cpu88_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu88_regfile (
    input  logic       clock,
    input  logic       resetn,
    input  logic       locked,
    cpu88_ctrl_if.regs ctrl
);
    import cpu88_pkg::*;

    word_t regs [8];

    always_ff @(posedge clock) begin
        if (!resetn) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (locked) begin
            if (ctrl.reg_we) begin
                regs[ctrl.wr_idx] <= ctrl.wr_data;
            end
            // Stack pointer drops at the low byte write
            if (ctrl.push_start) begin
                regs[SP_IDX] <= regs[SP_IDX] - 16'd2;
            end
        end
    end

    assign ctrl.rdata_a = regs[ctrl.rd_a];
    assign ctrl.rdata_b = regs[ctrl.rd_b];
    assign ctrl.sp      = regs[SP_IDX];

endmodule

`default_nettype wire

// ==== hw/cpu88_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu88_alu (
    input  logic              clock,
    input  logic              resetn,
    input  logic              locked,
    cpu88_ctrl_if.alu         ctrl,
    input  cpu88_pkg::word_t  imm,
    output cpu88_pkg::word_t  wb
);
    import cpu88_pkg::*;

    word_t       op_a;
    word_t       op_b;
    logic [16:0] sum;
    logic [16:0] diff;
    word_t       result;
    logic        cf_new;
    logic        of_new;
    logic        cond_raw;
    flags_t      flags_q;

    assign op_a = ctrl.rdata_a;
    assign op_b = ctrl.alu_inc ? 16'd1 : ctrl.rdata_b;
    assign sum  = {1'b0, op_a} + {1'b0, op_b};
    assign diff = {1'b0, op_a} - {1'b0, op_b};

    always_comb begin
        result = op_a;
        cf_new = 1'b0;
        of_new = 1'b0;
        case (ctrl.alu_op)
            ADD: begin
                result = sum[15:0];
                cf_new = sum[16];
                of_new = (op_a[15] == op_b[15]) && (sum[15] != op_a[15]);
            end
            SUB, CMP: begin
                result = diff[15:0];
                cf_new = diff[16];
                of_new = (op_a[15] != op_b[15]) && (diff[15] != op_a[15]);
            end
            OR:  result = op_a | op_b;
            AND: result = op_a & op_b;
            XOR: result = op_a ^ op_b;
            default: result = op_a;
        endcase
    end

    // ==================================================
    // Flags
    // ==================================================

    always_ff @(posedge clock) begin
        if (!resetn) begin
            flags_q <= '0;
        end else if (locked) begin
            if (ctrl.alu_go) begin
                flags_q[ZF_BIT] <= (result == '0);
                flags_q[SF_BIT] <= result[15];
                flags_q[OF_BIT] <= of_new;
                // INC and DEC leave carry alone
                if (!ctrl.alu_inc) begin
                    flags_q[CF_BIT] <= cf_new;
                end
            end
            case (ctrl.flag_op)
                FLAG_CLC: flags_q[CF_BIT] <= 1'b0;
                FLAG_STC: flags_q[CF_BIT] <= 1'b1;
                FLAG_CMC: flags_q[CF_BIT] <= ~flags_q[CF_BIT];
                default: ;
            endcase
        end
    end

    // Opcode bits 3..1 pick the flag and bit 0 inverts the test
    always_comb begin
        case (ctrl.cond[3:1])
            3'd0:    cond_raw = flags_q[OF_BIT];
            3'd1:    cond_raw = flags_q[CF_BIT];
            3'd2:    cond_raw = flags_q[ZF_BIT];
            3'd4:    cond_raw = flags_q[SF_BIT];
            default: cond_raw = 1'b0;
        endcase
    end

    assign ctrl.branch_true = cond_raw ^ ctrl.cond[0];
    assign ctrl.flags       = flags_q;
    assign wb               = ctrl.wb_sel ? imm : result;

endmodule

`default_nettype wire

// ==== hw/cpu88_bus_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu88_bus_unit #(
    parameter cpu88_pkg::word_t RESET_IP = 16'h0100
) (
    input  logic              clock,
    input  logic              resetn,
    input  logic              locked,
    input  logic [7:0]        bus,
    cpu88_ctrl_if.bus         ctrl,
    input  cpu88_pkg::flags_t flags,
    input  cpu88_pkg::word_t  push_word,
    input  cpu88_pkg::word_t  sp,
    output cpu88_pkg::word_t  imm,
    output cpu88_pkg::addr_t  address,
    output logic [7:0]        data,
    output logic              wreq
);
    import cpu88_pkg::*;

    word_t      ip;
    word_t      push_sel;
    word_t      stack_off;
    logic [7:0] push_hi_byte;

    // ==================================================
    // Instruction pointer
    // ==================================================

    always_ff @(posedge clock) begin
        if (!resetn) begin
            ip <= RESET_IP;
        end else if (locked) begin
            if (ctrl.ip_branch) begin
                ip <= ip + 16'd1 + {{8{bus[7]}}, bus};
            end else if (ctrl.ip_dec) begin
                ip <= ip - 16'd1;
            end else if (ctrl.ip_inc) begin
                ip <= ip + 16'd1;
            end
        end
    end

    // Immediate bytes and the pushed high byte
    always_ff @(posedge clock) begin
        if (locked) begin
            if (ctrl.imm_load_lo) begin
                imm[7:0] <= bus;
            end
            if (ctrl.imm_load_hi) begin
                imm[15:8] <= bus;
            end
            // Captured before SP moves
            if (ctrl.push_start) begin
                push_hi_byte <= push_sel[15:8];
            end
        end
    end

    assign push_sel = ctrl.push_src ? {4'h0, flags} : push_word;
    assign wreq     = ctrl.push_start | ctrl.push_hi;

    // SP is already lowered by the high byte cycle
    assign stack_off = ctrl.push_hi ? sp + 16'd1 : sp - 16'd2;

    assign address = wreq ? {STACK_SEG, 4'h0} + addr_t'(stack_off)
                          : {RESET_CS, 4'h0} + addr_t'(ip);
    assign data    = ctrl.push_hi ? push_hi_byte : push_sel[7:0];

endmodule

`default_nettype wire

// ==== hw/cpu88_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu88_top #(
    parameter cpu88_pkg::word_t RESET_IP   = 16'h0100,
    parameter int               STEP_WIDTH = 3
) (
    input  logic             clock,
    input  logic             resetn,
    input  logic             locked,
    output cpu88_pkg::addr_t address,
    input  logic [7:0]       bus,
    output logic [7:0]       data,
    output logic             wreq
);
    import cpu88_pkg::*;

    logic [STEP_WIDTH-1:0] step_count;
    logic                  step_last;
    logic                  step_clear;
    logic                  step_advance;
    word_t                 imm;

    cpu88_ctrl_if ctrl ();

    cpu88_sequencer #(
        .STEP_WIDTH(STEP_WIDTH)
    ) u_seq (
        .clock       (clock),
        .resetn      (resetn),
        .locked      (locked),
        .bus         (bus),
        .ctrl        (ctrl),
        .step_count  (step_count),
        .step_last   (step_last),
        .step_clear  (step_clear),
        .step_advance(step_advance)
    );

    cpu88_step_counter #(
        .STEP_WIDTH(STEP_WIDTH)
    ) u_steps (
        .clock  (clock),
        .resetn (resetn),
        .locked (locked),
        .clear  (step_clear),
        .advance(step_advance),
        .count  (step_count),
        .last   (step_last)
    );

    cpu88_regfile u_regs (
        .clock (clock),
        .resetn(resetn),
        .locked(locked),
        .ctrl  (ctrl)
    );

    cpu88_alu u_alu (
        .clock (clock),
        .resetn(resetn),
        .locked(locked),
        .ctrl  (ctrl),
        .imm   (imm),
        .wb    (ctrl.wr_data)
    );

    cpu88_bus_unit #(
        .RESET_IP(RESET_IP)
    ) u_bus (
        .clock    (clock),
        .resetn   (resetn),
        .locked   (locked),
        .bus      (bus),
        .ctrl     (ctrl),
        .flags    (ctrl.flags),
        .push_word(ctrl.rdata_a),
        .sp       (ctrl.sp),
        .imm      (imm),
        .address  (address),
        .data     (data),
        .wreq     (wreq)
    );

endmodule

`default_nettype wire

// ==== testbench/cpu88_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu88_props (
    input logic             clock,
    input logic             resetn,
    input logic             locked,
    input cpu88_pkg::addr_t address,
    input logic             wreq
);
    import cpu88_pkg::*;

    logic [1:0] wr_run;
    addr_t      first_addr;

    // Enabled write cycles in the current burst
    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_run <= '0;
        end else if (locked) begin
            if (wreq) begin
                wr_run <= wr_run + 2'd1;
                if (wr_run == 2'd0) first_addr <= address;
            end else begin
                wr_run <= '0;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clock) !resetn |=> !wreq)
        else $error("wreq high after reset");

    a_write_max: assert property (@(posedge clock) disable iff (!resetn)
        (locked && wreq) |-> wr_run < 2'd2)
        else $error("write burst longer than two cycles");

    a_write_pair: assert property (@(posedge clock) disable iff (!resetn)
        (locked && !wreq) |-> wr_run != 2'd1)
        else $error("write burst of a single cycle");

    a_second_addr: assert property (@(posedge clock) disable iff (!resetn)
        (locked && wreq && wr_run == 2'd1) |-> address == first_addr + 20'd1)
        else $error("second write address not one above the first");

    a_hold: assert property (@(posedge clock) disable iff (!resetn)
        !locked |=> $stable(address) && $stable(wreq))
        else $error("address or wreq moved while locked was low");

endmodule

bind cpu88_top cpu88_props u_props (
    .clock  (clock),
    .resetn (resetn),
    .locked (locked),
    .address(address),
    .wreq   (wreq)
);

`default_nettype wire

// ==== testbench/tb_cpu88.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu88;
    import cpu88_pkg::*;

    localparam word_t RESET_IP = 16'h0100;

    logic        clock;
    logic        resetn;
    logic        locked;
    addr_t       address;
    logic [7:0]  bus;
    logic [7:0]  data;
    logic        wreq;

    logic [7:0]  prog [65536];
    logic [27:0] exp_q [$];
    addr_t       head_addr;
    logic [7:0]  head_data;
    logic        head_valid;
    addr_t       offs;
    addr_t       hlt_addr;
    word_t       pc;
    word_t       r [8];
    logic        cf;
    logic        zf;
    logic        sf;
    logic        of;
    int          n_instr;
    int          cycles;
    int          hold;
    int          limit;

    cpu88_top #(
        .RESET_IP  (RESET_IP),
        .STEP_WIDTH(3)
    ) UUT (
        .clock  (clock),
        .resetn (resetn),
        .locked (locked),
        .address(address),
        .bus    (bus),
        .data   (data),
        .wreq   (wreq)
    );

    // Program memory answers in the same cycle
    assign offs = address - {RESET_CS, 4'h0};
    assign bus  = (offs < 20'h10000) ? prog[offs[15:0]] : 8'h00;

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // ==================================================
    // Program generator and reference model
    // ==================================================

    task automatic emit(input logic [7:0] b);
        prog[pc] = b;
        pc = pc + 16'd1;
    endtask

    task automatic expect_word(input word_t w);
        addr_t a;
        r[4] = r[4] - 16'd2;
        a = {STACK_SEG, 4'h0} + addr_t'(r[4]);
        exp_q.push_back({a, w[7:0]});
        exp_q.push_back({a + 20'd1, w[15:8]});
    endtask

    function automatic word_t flags_word();
        word_t w;
        w = '0;
        w[CF_BIT] = cf;
        w[ZF_BIT] = zf;
        w[SF_BIT] = sf;
        w[OF_BIT] = of;
        return w;
    endfunction

    task automatic mov_imm(input reg_idx_t idx, input word_t v);
        n_instr++;
        emit(8'hB8 | 8'(idx));
        emit(v[7:0]);
        emit(v[15:8]);
        r[idx] = v;
    endtask

    task automatic emit_push(input reg_idx_t idx);
        n_instr++;
        emit(8'h50 | 8'(idx));
    endtask

    task automatic push_reg(input reg_idx_t idx);
        emit_push(idx);
        expect_word(r[idx]);
    endtask

    task automatic pushf();
        n_instr++;
        emit(8'h9C);
        expect_word(flags_word());
    endtask

    task automatic alu_rr(input alu_op_e op, input reg_idx_t dst, input reg_idx_t src);
        word_t a;
        word_t b;
        word_t res;
        logic [16:0] t;
        logic [16:0] s;
        a = r[dst];
        b = r[src];
        n_instr++;
        emit(8'h01 | {2'b00, op, 3'b000});
        emit(8'hC0 | {2'b00, src, dst});
        case (op)
            ADD: begin
                t = {1'b0, a} + {1'b0, b};
                s = {a[15], a} + {b[15], b};
                res = t[15:0];
                cf = t[16];
                of = s[16] ^ s[15];
            end
            SUB, CMP: begin
                s = {a[15], a} - {b[15], b};
                res = a - b;
                cf = (a < b);
                of = s[16] ^ s[15];
            end
            OR: begin
                res = a | b;
                cf = 0;
                of = 0;
            end
            AND: begin
                res = a & b;
                cf = 0;
                of = 0;
            end
            default: begin
                res = a ^ b;
                cf = 0;
                of = 0;
            end
        endcase
        zf = (res == 16'd0);
        sf = res[15];
        if (op != CMP) r[dst] = res;
    endtask

    task automatic inc_dec(input logic dec, input reg_idx_t idx);
        word_t a;
        a = r[idx];
        n_instr++;
        emit(dec ? (8'h48 | 8'(idx)) : (8'h40 | 8'(idx)));
        r[idx] = dec ? a - 16'd1 : a + 16'd1;
        of = dec ? (a == 16'h8000) : (a == 16'h7FFF);
        zf = (r[idx] == 16'd0);
        sf = r[idx][15];
    endtask

    // Load AX and CX so that they match about half the time
    task automatic set_flags_random();
        word_t v;
        v = 16'($urandom);
        mov_imm(0, v);
        mov_imm(1, ($urandom_range(1, 0) != 0) ? v : 16'($urandom));
    endtask

    task automatic build_program();
        logic [7:0] jcc [8];
        logic       taken;
        alu_op_e    ops [6];
        jcc = '{8'h70, 8'h71, 8'h72, 8'h73, 8'h74, 8'h75, 8'h78, 8'h79};
        ops = '{ADD, OR, AND, SUB, XOR, CMP};
        for (int i = 0; i < 65536; i++) prog[i] = 8'(i) ^ 8'(i >> 8);
        for (int i = 0; i < 8; i++) r[i] = '0;
        {cf, zf, sf, of} = '0;
        pc = RESET_IP;
        n_instr = 0;
        mov_imm(4, {2'b01, 13'($urandom), 1'b0});
        for (int i = 0; i < 8; i++) begin
            if (i != 4) begin
                mov_imm(reg_idx_t'(i), 16'($urandom));
                push_reg(reg_idx_t'(i));
            end
        end
        foreach (ops[i]) begin
            set_flags_random();
            alu_rr(ops[i], 0, 1);
            push_reg(0);
            pushf();
        end
        mov_imm(2, 16'h7FFF);
        inc_dec(1'b0, 2);
        push_reg(2);
        pushf();
        mov_imm(3, 16'($urandom));
        inc_dec(1'b1, 3);
        push_reg(3);
        pushf();
        n_instr++;
        emit(8'hF8);
        cf = 1'b0;
        pushf();
        n_instr++;
        emit(8'hF9);
        cf = 1'b1;
        pushf();
        n_instr++;
        emit(8'hF5);
        cf = ~cf;
        pushf();
        for (int k = 0; k < 16; k++) begin
            set_flags_random();
            alu_rr(CMP, 0, 1);
            case (jcc[k % 8])
                8'h70:   taken = of;
                8'h71:   taken = !of;
                8'h72:   taken = cf;
                8'h73:   taken = !cf;
                8'h74:   taken = zf;
                8'h75:   taken = !zf;
                8'h78:   taken = sf;
                default: taken = !sf;
            endcase
            n_instr++;
            emit(jcc[k % 8]);
            emit(8'h01);
            emit_push(6);
            if (!taken) expect_word(r[6]);
            push_reg(7);
        end
        n_instr++;
        emit(8'hEB);
        emit(8'h01);
        emit_push(6);
        push_reg(7);
        hlt_addr = {RESET_CS, 4'h0} + addr_t'(pc);
        n_instr++;
        emit(8'hF4);
    endtask

    // ==================================================
    // Write checking
    // ==================================================

    task automatic load_head();
        if (exp_q.size() > 0) begin
            {head_addr, head_data} = exp_q[0];
            head_valid = 1'b1;
        end else begin
            head_valid = 1'b0;
        end
    endtask

    always @(posedge clock) begin
        if (resetn && locked && wreq && exp_q.size() > 0) void'(exp_q.pop_front());
        load_head();
    end

    assert property (@(posedge clock) disable iff (!resetn) (wreq && locked) |-> head_valid)
        else report_fail("Unexpected write after all expected bytes were written");

    assert property (@(posedge clock) disable iff (!resetn)
        (wreq && locked && head_valid) |-> address == head_addr)
        else report_fail($sformatf("MISMATCH address expected %05h actual %05h",
            $sampled(head_addr), $sampled(address)));

    assert property (@(posedge clock) disable iff (!resetn)
        (wreq && locked && head_valid) |-> data == head_data)
        else report_fail($sformatf("MISMATCH data expected %02h actual %02h",
            $sampled(head_data), $sampled(data)));

    initial begin
        void'($urandom(32'h5ed2));
        resetn = 1'b0;
        locked = 1'b1;
        build_program();
        load_head();
        repeat (10) @(posedge clock);
        #1 resetn = 1'b1;
        assert (!wreq) else report_fail($sformatf("MISMATCH wreq expected 0 actual %0h", wreq));
        assert (address == {RESET_CS, 4'h0} + addr_t'(RESET_IP))
            else report_fail($sformatf("MISMATCH address expected %05h actual %05h",
                {RESET_CS, 4'h0} + addr_t'(RESET_IP), address));
        fork
            forever begin
                @(posedge clock);
                #1 locked = ($urandom_range(7, 0) != 0);
            end
        join_none
        limit = 40 * n_instr;
        cycles = 0;
        hold = 0;
        while (hold < 16) begin
            @(negedge clock);
            cycles++;
            hold = (address == hlt_addr) ? hold + 1 : 0;
            if (cycles > limit) report_fail("Timeout before the core settled on HLT");
        end
        if (exp_q.size() != 0) begin
            report_fail($sformatf("Run ended with %0d expected bytes never written",
                exp_q.size()));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/cpu88_pkg.sv
hw/cpu88_ctrl_if.sv
hw/cpu88_sequencer.sv
hw/cpu88_step_counter.sv
hw/cpu88_regfile.sv
hw/cpu88_alu.sv
hw/cpu88_bus_unit.sv
hw/cpu88_top.sv
testbench/cpu88_props.sv
testbench/tb_cpu88.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu88
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(OBJ_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_TEXT)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)
